//--- verilog/sd_dat_pkg.sv
package sd_dat_pkg;

    // bus geometry
    localparam int DAT_LANES = 8;
    localparam int WORD_W    = 32;
    localparam int BLKSIZE_W = 12;

    // crc16 on each dat line
    localparam int CRC_W = 16;
    localparam logic [CRC_W-1:0] CRC16_POLY = 16'h1021;

    // bus width codes, code 3 falls back to 1-bit
    localparam logic [1:0] BUS_W1 = 2'd0;
    localparam logic [1:0] BUS_W4 = 2'd1;
    localparam logic [1:0] BUS_W8 = 2'd2;

    // one fifo word, byte view for 8-bit mode and nibble view for 4-bit mode
    typedef union packed {
        logic [WORD_W/8-1:0][7:0] bytes;
        logic [WORD_W/4-1:0][3:0] nibbles;
    } sd_word_u;

endpackage

//--- verilog/sd_dat_lane_if.sv
`timescale 1ns/1ps

interface sd_dat_lane_if #(
    parameter int LANES = sd_dat_pkg::DAT_LANES
);

    logic [LANES-1:0] lane_bit;
    logic [LANES-1:0] lane_act;
    logic             crc_clr;
    logic             crc_run;
    logic             crc_shift;
    logic             phase_start;
    logic             phase_end;
    // one driver per bit, one crc lane each
    wire  [LANES-1:0] crc_bit;

    modport feeder (
        output lane_bit,
        output lane_act,
        output crc_clr,
        output crc_run,
        output crc_shift,
        output phase_start,
        output phase_end
    );

    modport lane (
        input  lane_bit,
        input  crc_clr,
        input  crc_run,
        input  crc_shift,
        output crc_bit
    );

    modport drain (
        input  lane_bit,
        input  lane_act,
        input  crc_run,
        input  crc_shift,
        input  phase_start,
        input  phase_end,
        input  crc_bit
    );

endinterface

//--- verilog/sd_dat_serializer.sv
`timescale 1ns/1ps

module sd_dat_serializer #(
    parameter int LANES = sd_dat_pkg::DAT_LANES
) (
    input  logic                            sd_clk,
    input  logic                            reset_i,
    input  logic                            start_i,
    input  logic [1:0]                      bus_width_i,
    input  logic [sd_dat_pkg::BLKSIZE_W-1:0] blksize_i,
    input  logic [sd_dat_pkg::WORD_W-1:0]   word_i,
    output logic                            word_rd_o,
    output logic                            busy_o,
    sd_dat_lane_if.feeder                   lanes
);

    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_LOAD  = 3'd1;
    localparam logic [2:0] ST_START = 3'd2;
    localparam logic [2:0] ST_DATA  = 3'd3;
    localparam logic [2:0] ST_CRC   = 3'd4;
    localparam logic [2:0] ST_STOP  = 3'd5;
    localparam logic [2:0] ST_TAIL  = 3'd6;

    localparam int CRC_CNT_W = $clog2(sd_dat_pkg::CRC_W);

    logic [2:0]                       state;
    logic [1:0]                       width_q;
    logic [1:0]                       width_sel;
    logic [2:0]                       bit_pos;
    logic [1:0]                       byte_pos;
    logic [sd_dat_pkg::BLKSIZE_W-1:0] byte_cnt;
    logic [CRC_CNT_W-1:0]             crc_cnt;
    logic [2:0]                       last_bit;
    logic                             byte_done;
    logic                             word_last;
    logic                             blk_last;

    sd_dat_pkg::sd_word_u             word_v;
    logic [7:0]                       cur_byte;
    logic [3:0]                       cur_nib;
    logic [7:0]                       bits_all;
    logic [7:0]                       act_all;

    // 8-bit mode needs all eight lanes
    always_comb begin
        width_sel = sd_dat_pkg::BUS_W1;
        if (bus_width_i == sd_dat_pkg::BUS_W4) begin
            width_sel = sd_dat_pkg::BUS_W4;
        end else if (bus_width_i == sd_dat_pkg::BUS_W8 && LANES >= 8) begin
            width_sel = sd_dat_pkg::BUS_W8;
        end
    end

    // cycles per byte minus one
    always_comb begin
        case (width_q)
            sd_dat_pkg::BUS_W4: last_bit = 3'd1;
            sd_dat_pkg::BUS_W8: last_bit = 3'd0;
            default:            last_bit = 3'd7;
        endcase
    end

    assign byte_done = (bit_pos == last_bit);
    assign word_last = byte_done && (byte_pos == 2'd3);
    assign blk_last  = (byte_cnt == {{(sd_dat_pkg::BLKSIZE_W-1){1'b0}}, 1'b1});

    always_ff @(posedge sd_clk) begin
        if (reset_i) begin
            state    <= ST_IDLE;
            width_q  <= sd_dat_pkg::BUS_W1;
            bit_pos  <= 3'd0;
            byte_pos <= 2'd0;
            byte_cnt <= '0;
            crc_cnt  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_i) begin
                        state    <= ST_LOAD;
                        width_q  <= width_sel;
                        byte_cnt <= blksize_i;
                    end
                end
                ST_LOAD: begin
                    state    <= ST_START;
                    bit_pos  <= 3'd0;
                    byte_pos <= 2'd0;
                    crc_cnt  <= '0;
                end
                ST_START: begin
                    state <= ST_DATA;
                end
                ST_DATA: begin
                    if (byte_done) begin
                        bit_pos  <= 3'd0;
                        byte_pos <= byte_pos + 2'd1;
                        byte_cnt <= byte_cnt - 1'b1;
                        if (blk_last) begin
                            state <= ST_CRC;
                        end
                    end else begin
                        bit_pos <= bit_pos + 3'd1;
                    end
                end
                ST_CRC: begin
                    crc_cnt <= crc_cnt + 1'b1;
                    if (crc_cnt == CRC_CNT_W'(sd_dat_pkg::CRC_W - 1)) begin
                        state <= ST_STOP;
                    end
                end
                ST_STOP: begin
                    state <= ST_TAIL;
                end
                // driver still shows the end bit here
                ST_TAIL: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // lsb byte first, high nibble before low nibble
    assign word_v   = word_i;
    assign cur_byte = word_v.bytes[byte_pos];
    assign cur_nib  = word_v.nibbles[{byte_pos, ~bit_pos[0]}];

    always_comb begin
        case (width_q)
            sd_dat_pkg::BUS_W4: begin
                bits_all = {4'h0, cur_nib};
                act_all  = 8'h0f;
            end
            sd_dat_pkg::BUS_W8: begin
                bits_all = cur_byte;
                act_all  = 8'hff;
            end
            default: begin
                bits_all = {7'h00, cur_byte[3'd7 - bit_pos]};
                act_all  = 8'h01;
            end
        endcase
    end

    assign lanes.lane_bit    = bits_all[LANES-1:0];
    assign lanes.lane_act    = act_all[LANES-1:0];
    assign lanes.crc_clr     = (state == ST_LOAD);
    assign lanes.crc_run     = (state == ST_DATA);
    assign lanes.crc_shift   = (state == ST_CRC);
    assign lanes.phase_start = (state == ST_START);
    assign lanes.phase_end   = (state == ST_STOP);

    // first word on entry, next one as the current word runs out
    assign word_rd_o = (state == ST_LOAD) || ((state == ST_DATA) && word_last && !blk_last);
    assign busy_o    = (state != ST_IDLE);

endmodule

//--- verilog/sd_crc16_lane.sv
`timescale 1ns/1ps

module sd_crc16_lane #(
    parameter int LANES = sd_dat_pkg::DAT_LANES,
    parameter int IDX   = 0
) (
    input  logic       sd_clk,
    input  logic       reset_i,
    sd_dat_lane_if.lane lanes
);

    // lane index kept inside the bus
    localparam int LANE = IDX % LANES;

    logic [sd_dat_pkg::CRC_W-1:0] crc_q;
    logic [sd_dat_pkg::CRC_W-1:0] crc_sh;
    logic                         fb;

    assign crc_sh = {crc_q[sd_dat_pkg::CRC_W-2:0], 1'b0};
    assign fb     = crc_q[sd_dat_pkg::CRC_W-1] ^ lanes.lane_bit[LANE];

    always_ff @(posedge sd_clk) begin
        if (reset_i || lanes.crc_clr) begin
            crc_q <= '0;
        end else if (lanes.crc_run) begin
            // x^16 + x^12 + x^5 + 1
            crc_q <= crc_sh ^ ({sd_dat_pkg::CRC_W{fb}} & sd_dat_pkg::CRC16_POLY);
        end else if (lanes.crc_shift) begin
            crc_q <= crc_sh;
        end
    end

    // msb goes out first
    assign lanes.crc_bit[LANE] = crc_q[sd_dat_pkg::CRC_W-1];

endmodule

//--- verilog/sd_dat_line_driver.sv
`timescale 1ns/1ps

module sd_dat_line_driver #(
    parameter int LANES = sd_dat_pkg::DAT_LANES
) (
    input  logic                             sd_clk,
    input  logic                             reset_i,
    sd_dat_lane_if.drain                     lanes,
    output logic [sd_dat_pkg::DAT_LANES-1:0] dat_o,
    output logic                             dat_oe_o
);

    logic [sd_dat_pkg::DAT_LANES-1:0] dat_next;
    logic                             oe_next;

    assign oe_next = lanes.phase_start | lanes.crc_run | lanes.crc_shift | lanes.phase_end;

    // end bit and unused lanes both sit at 1
    always_comb begin
        dat_next = '1;
        for (int i = 0; i < LANES; i++) begin
            if (lanes.lane_act[i]) begin
                if (lanes.phase_start) begin
                    dat_next[i] = 1'b0;
                end else if (lanes.crc_run) begin
                    dat_next[i] = lanes.lane_bit[i];
                end else if (lanes.crc_shift) begin
                    dat_next[i] = lanes.crc_bit[i];
                end
            end
        end
    end

    // one cycle behind the serializer
    always_ff @(posedge sd_clk) begin
        if (reset_i) begin
            dat_o    <= '1;
            dat_oe_o <= 1'b0;
        end else begin
            dat_o    <= dat_next;
            dat_oe_o <= oe_next;
        end
    end

endmodule

//--- verilog/sd_dat_tx_top.sv
`timescale 1ns/1ps

module sd_dat_tx_top #(
    parameter int LANES = sd_dat_pkg::DAT_LANES
) (
    input  logic                             sd_clk,
    input  logic                             reset_i,
    input  logic                             start_i,
    input  logic [1:0]                       bus_width_i,
    input  logic [sd_dat_pkg::BLKSIZE_W-1:0] blksize_i,
    input  logic [sd_dat_pkg::WORD_W-1:0]    word_i,
    output logic                             word_rd_o,
    output logic [sd_dat_pkg::DAT_LANES-1:0] dat_o,
    output logic                             dat_oe_o,
    output logic                             busy_o
);

    sd_dat_lane_if #(
        .LANES(LANES)
    ) lanes_if ();

    sd_dat_serializer #(
        .LANES(LANES)
    ) serializer0 (
        .sd_clk      (sd_clk),
        .reset_i     (reset_i),
        .start_i     (start_i),
        .bus_width_i (bus_width_i),
        .blksize_i   (blksize_i),
        .word_i      (word_i),
        .word_rd_o   (word_rd_o),
        .busy_o      (busy_o),
        .lanes       (lanes_if.feeder)
    );

    // one crc per dat line
    generate
        for (genvar g = 0; g < LANES; g++) begin : g_lane
            sd_crc16_lane #(
                .LANES(LANES),
                .IDX  (g)
            ) lane0 (
                .sd_clk  (sd_clk),
                .reset_i (reset_i),
                .lanes   (lanes_if.lane)
            );
        end
    endgenerate

    sd_dat_line_driver #(
        .LANES(LANES)
    ) driver0 (
        .sd_clk   (sd_clk),
        .reset_i  (reset_i),
        .lanes    (lanes_if.drain),
        .dat_o    (dat_o),
        .dat_oe_o (dat_oe_o)
    );

endmodule

//--- verif/sd_dat_tx_chk.sv
`timescale 1ns/1ps

module sd_dat_tx_chk (
    input logic sd_clk,
    input logic reset_i,
    input logic start_i,
    input logic word_rd_o,
    input logic dat_oe_o,
    input logic busy_o
);

    logic seen_start;
    int   fail_cnt = 0;

    always_ff @(posedge sd_clk) begin
        if (reset_i) begin
            seen_start <= 1'b0;
        end else if (start_i) begin
            seen_start <= 1'b1;
        end
    end

    a_oe_busy: assert property (@(posedge sd_clk) disable iff (reset_i) dat_oe_o |-> busy_o)
        else begin
            fail_cnt++;
            $error("dat_oe_o high while busy_o low");
        end

    a_rd_busy: assert property (@(posedge sd_clk) disable iff (reset_i) word_rd_o |-> busy_o)
        else begin
            fail_cnt++;
            $error("word_rd_o pulse while idle");
        end

    // idle until the first start after reset
    a_idle_reset: assert property (@(posedge sd_clk) disable iff (reset_i) !seen_start |-> !busy_o)
        else begin
            fail_cnt++;
            $error("busy_o high before any start_i");
        end

endmodule

bind sd_dat_tx_top sd_dat_tx_chk chk0 (
    .sd_clk    (sd_clk),
    .reset_i   (reset_i),
    .start_i   (start_i),
    .word_rd_o (word_rd_o),
    .dat_oe_o  (dat_oe_o),
    .busy_o    (busy_o)
);

//--- verif/sd_dat_tx_tb.sv
`timescale 1ns/1ps

module sd_dat_tx_tb;

    localparam int BLK_OVH     = 20;
    localparam int TIMEOUT_CYC = (128 + 128 + 512 + 64 + 64) + 5 * BLK_OVH + 200;

    logic        sd_clk;
    logic        reset_i;
    logic        start_i;
    logic [1:0]  bus_width_i;
    logic [11:0] blksize_i;
    logic [31:0] word_i;
    logic        word_rd_o;
    logic [7:0]  dat_o;
    logic        dat_oe_o;
    logic        busy_o;

    logic [31:0] fifo_mem [0:255];
    int          rd_idx;
    int          rd_cnt;
    int          err_cnt;
    int          chk_cnt;
    int          cyc_cnt;
    int          seed;

    sd_dat_tx_top dut0 (
        .sd_clk      (sd_clk),
        .reset_i     (reset_i),
        .start_i     (start_i),
        .bus_width_i (bus_width_i),
        .blksize_i   (blksize_i),
        .word_i      (word_i),
        .word_rd_o   (word_rd_o),
        .dat_o       (dat_o),
        .dat_oe_o    (dat_oe_o),
        .busy_o      (busy_o)
    );

    always #4 sd_clk = ~sd_clk;

    // fifo pops on the read pulse and shows the word a cycle later
    always @(negedge sd_clk) begin
        if (word_rd_o) begin
            rd_cnt++;
            @(posedge sd_clk);
            #1;
            word_i = fifo_mem[rd_idx];
            rd_idx++;
        end
    end

    always @(posedge sd_clk) begin
        cyc_cnt++;
        if (cyc_cnt >= TIMEOUT_CYC) begin
            $display("timeout: run exceeded %0d cycles, block never finished", TIMEOUT_CYC);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_dat(input logic [7:0] got, input logic [7:0] exp, input string what);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t: %s dat_o %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input sd_dat_pkg::sd_word_u got, input sd_dat_pkg::sd_word_u exp,
                              input string what);
        chk_cnt++;
        if (got.bytes !== exp.bytes) begin
            err_cnt++;
            $display("[ERROR] %0t: %s got %0d expected %0d", $time, what, got.bytes, exp.bytes);
        end
    endtask

    function automatic logic [7:0] blk_byte(input int j);
        return fifo_mem[j / 4][8 * (j % 4) +: 8];
    endfunction

    function automatic logic [7:0] lane_mask(input int w);
        return 8'((1 << w) - 1);
    endfunction

    // expected lanes for one data cycle
    function automatic logic [7:0] exp_data(input int w, input int cyc);
        logic [7:0] b;
        logic [7:0] v;
        v = 8'hff;
        if (w == 1) begin
            b = blk_byte(cyc / 8);
            v[0] = b[7 - cyc % 8];
        end else if (w == 4) begin
            b = blk_byte(cyc / 2);
            v[3:0] = (cyc % 2 == 0) ? b[7:4] : b[3:0];
        end else begin
            v = blk_byte(cyc);
        end
        return v;
    endfunction

    function automatic logic [15:0] exp_crc(input int w, input int lane, input int ncyc);
        logic [15:0] crc;
        logic [7:0]  v;
        logic        fb;
        crc = 16'h0000;
        for (int i = 0; i < ncyc; i++) begin
            v   = exp_data(w, i);
            fb  = crc[15] ^ v[lane];
            crc = {crc[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
        end
        return crc;
    endfunction

    task automatic start_block(input int w, input int nbytes);
        for (int i = 0; i < nbytes / 4; i++) begin
            fifo_mem[i] = $random(seed);
        end
        rd_idx = 0;
        rd_cnt = 0;
        @(posedge sd_clk);
        #1;
        start_i     = 1'b1;
        bus_width_i = (w == 8) ? sd_dat_pkg::BUS_W8 :
                      (w == 4) ? sd_dat_pkg::BUS_W4 : sd_dat_pkg::BUS_W1;
        blksize_i   = 12'(nbytes);
        @(posedge sd_clk);
        #1;
        start_i = 1'b0;
    endtask

    task automatic check_block(input int w, input int nbytes);
        int                 ncyc;
        logic [7:0]         mask;
        logic [7:0]         v;
        logic [15:0]        crcs [0:7];
        sd_dat_pkg::sd_word_u got_words;
        sd_dat_pkg::sd_word_u exp_words;
        ncyc = nbytes * 8 / w;
        mask = lane_mask(w);
        for (int l = 0; l < w; l++) begin
            crcs[l] = exp_crc(w, l, ncyc);
        end
        @(negedge sd_clk);
        while (!dat_oe_o) begin
            @(negedge sd_clk);
        end
        check_dat(dat_o, ~mask, "start bit");
        for (int i = 0; i < ncyc; i++) begin
            @(negedge sd_clk);
            check_bit(dat_oe_o, 1'b1, "enable in data phase");
            check_dat(dat_o, exp_data(w, i), $sformatf("data cycle %0d", i));
        end
        for (int k = 0; k < 16; k++) begin
            @(negedge sd_clk);
            v = ~mask;
            for (int l = 0; l < w; l++) begin
                v[l] = crcs[l][15 - k];
            end
            check_bit(dat_oe_o, 1'b1, "enable in crc phase");
            check_dat(dat_o, v, $sformatf("crc bit %0d", k));
        end
        @(negedge sd_clk);
        check_bit(dat_oe_o, 1'b1, "enable on end bit");
        check_dat(dat_o, 8'hff, "end bit");
        @(negedge sd_clk);
        check_bit(dat_oe_o, 1'b0, "enable after end bit");
        check_bit(busy_o, 1'b0, "busy after end bit");
        check_dat(dat_o, 8'hff, "idle lanes");
        got_words = 32'(rd_cnt);
        exp_words = 32'(nbytes / 4);
        check_word(got_words, exp_words, "words fetched");
    endtask

    task automatic test_reset_idle();
        repeat (5) begin
            @(negedge sd_clk);
            check_bit(busy_o, 1'b0, "busy after reset");
            check_bit(dat_oe_o, 1'b0, "enable after reset");
            check_bit(word_rd_o, 1'b0, "read strobe after reset");
            check_dat(dat_o, 8'hff, "dat after reset");
        end
    endtask

    task automatic test_bus1();
        start_block(1, 16);
        check_block(1, 16);
    endtask

    task automatic test_bus4();
        start_block(4, 64);
        check_block(4, 64);
    endtask

    task automatic test_bus8();
        start_block(8, 512);
        check_block(8, 512);
    endtask

    task automatic test_start_busy();
        start_block(4, 32);
        fork
            check_block(4, 32);
            begin
                // second start mid-block with a different size
                repeat (10) @(posedge sd_clk);
                #1;
                start_i     = 1'b1;
                bus_width_i = sd_dat_pkg::BUS_W1;
                blksize_i   = 12'd8;
                @(posedge sd_clk);
                #1;
                start_i = 1'b0;
            end
        join
        repeat (4) begin
            @(negedge sd_clk);
            check_bit(busy_o, 1'b0, "busy after ignored start");
        end
        start_block(1, 8);
        check_block(1, 8);
    endtask

    initial begin
        seed        = 37;
        sd_clk      = 1'b0;
        reset_i     = 1'b1;
        start_i     = 1'b0;
        bus_width_i = sd_dat_pkg::BUS_W1;
        blksize_i   = '0;
        word_i      = '0;
        rd_idx      = 0;
        rd_cnt      = 0;
        err_cnt     = 0;
        chk_cnt     = 0;
        cyc_cnt     = 0;
        repeat (2) @(posedge sd_clk);
        #1;
        reset_i = 1'b0;
        test_reset_idle();
        test_bus1();
        test_bus4();
        test_bus8();
        test_start_busy();
        repeat (4) @(posedge sd_clk);
        $display("checks: %0d  errors: %0d  assertion failures: %0d",
                 chk_cnt, err_cnt, dut0.chk0.fail_cnt);
        if (err_cnt == 0 && dut0.chk0.fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
verilog/sd_dat_pkg.sv
verilog/sd_dat_lane_if.sv
verilog/sd_dat_serializer.sv
verilog/sd_crc16_lane.sv
verilog/sd_dat_line_driver.sv
verilog/sd_dat_tx_top.sv
verif/sd_dat_tx_chk.sv
verif/sd_dat_tx_tb.sv
